// File: src/ramio_settings.svh
////////////////////
// memory and I/O block settings
// widths, clocking and memory-mapped I/O addresses
////////////////////
`ifndef RAMIO_SETTINGS_SVH
`define RAMIO_SETTINGS_SVH

// RAM depth in 32-bit words is 2**width
`define RAMIO_ADDR_WIDTH 10

`define RAMIO_CLK_FREQ 25_000_000   // 40 ns clock
`define RAMIO_BAUD_RATE 3_125_000   // 8 clocks per bit

// I/O registers at the top of the byte address space
`define RAMIO_ADDR_LEDS ((1 << (`RAMIO_ADDR_WIDTH + 2)) - 1)
`define RAMIO_ADDR_UART_OUT (`RAMIO_ADDR_LEDS - 1)
`define RAMIO_ADDR_UART_IN (`RAMIO_ADDR_LEDS - 2)

`endif

// File: src/ramioPkg.sv
////////////////////
// memory and I/O types
// bus vectors and UART state encodings
////////////////////
`include "ramio_settings.svh"

package ramioPkg;

  typedef logic [`RAMIO_ADDR_WIDTH+1:0] byteAddr_t;  // address in bytes
  typedef logic [`RAMIO_ADDR_WIDTH-1:0] wordAddr_t;  // RAM word index
  typedef logic [31:0] word_t;
  typedef logic [7:0] byte_t;
  typedef logic [3:0] byteEn_t;     // one bit per byte lane

  // 0 none, 1 byte, 2 half word, 3 word
  typedef logic [1:0] writeSize_t;
  // bit 2 selects sign extension, low bits coded as for writes
  typedef logic [2:0] readSize_t;

  typedef logic [5:0] ledBits_t;

  typedef enum logic [1:0] {txIdle, txStart, txData, txStop} uartTxState_t;
  typedef enum logic [2:0] {rxIdle, rxStart, rxData, rxStop, rxDone} uartRxState_t;

endpackage

// File: src/ramPort.sv
////////////////////
// RAM port A bus
// word addressed, byte enables, no handshake
////////////////////
`timescale 1ns/1ps

interface ramPort;
  import ramioPkg::*;

  wordAddr_t addr;  // word index
  byteEn_t we;      // lane write enables
  word_t din;       // lane-steered store data
  word_t dout;      // word at the previous edge's address

  // ramIo side
  modport master(output addr, output we, output din, input dout);
  // RAM side
  modport slave(input addr, input we, input din, output dout);

endinterface

// File: src/ram.sv
////////////////////
// dual-port RAM
// byte-lane writes and registered read on A, registered read on B
////////////////////
`timescale 1ns/1ps
`include "ramio_settings.svh"

module ram #(
  parameter int ADDR_WIDTH = `RAMIO_ADDR_WIDTH
) (
  input logic clk,
  ramPort.slave portA,                 // data port
  input ramioPkg::wordAddr_t addrB,    // instruction fetch word index
  output ramioPkg::word_t doutB
);
  import ramioPkg::*;

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  word_t mem [DEPTH];  // filled through port A

  always_ff @(posedge clk) begin
    // per-lane write, untouched lanes keep their bytes
    for (int lane = 0; lane < 4; lane++) begin
      if (portA.we[lane]) begin
        mem[portA.addr][8*lane +: 8] <= portA.din[8*lane +: 8];
      end
    end
    portA.dout <= mem[portA.addr];  // read before write on the same word
    doutB <= mem[addrB];            // fetch port, read only
  end

endmodule

// File: src/uartTx.sv
////////////////////
// UART transmitter
// 8N1 frames, go/busy handshake
////////////////////
`timescale 1ns/1ps
`include "ramio_settings.svh"

module uartTx #(
  parameter int CLK_FREQ = `RAMIO_CLK_FREQ,
  parameter int BAUD_RATE = `RAMIO_BAUD_RATE
) (
  input logic clk,
  input logic rst,
  input ramioPkg::byte_t data,  // held stable while go is high
  input logic go,               // request held until after bsy falls
  output logic tx,              // serial line idles high
  output logic bsy              // high for the whole frame
);
  import ramioPkg::*;

  localparam int BIT_CLKS = CLK_FREQ / BAUD_RATE;
  localparam int CNT_W = $clog2(BIT_CLKS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(BIT_CLKS - 1);

  uartTxState_t state;
  logic [CNT_W-1:0] baudCnt;  // clocks within the current bit
  logic [2:0] bitIdx;         // data bit being sent
  byte_t shiftReg;            // LSB goes out first

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= txIdle;
      tx <= 1'b1;
      bsy <= 1'b0;
      baudCnt <= '0;
      bitIdx <= '0;
    end else begin
      baudCnt <= baudCnt + 1'b1;
      unique case (state)
        txIdle: begin
          baudCnt <= '0;
          if (go) begin
            shiftReg <= data;
            tx <= 1'b0;  // start bit
            bsy <= 1'b1;
            state <= txStart;
          end
        end
        txStart: if (baudCnt == BIT_LAST) begin
          baudCnt <= '0;
          bitIdx <= '0;
          tx <= shiftReg[0];
          shiftReg <= shiftReg >> 1;
          state <= txData;
        end
        txData: if (baudCnt == BIT_LAST) begin
          baudCnt <= '0;
          bitIdx <= bitIdx + 1'b1;
          if (bitIdx == 3'd7) begin
            tx <= 1'b1;  // stop bit
            state <= txStop;
          end else begin
            tx <= shiftReg[0];
            shiftReg <= shiftReg >> 1;
          end
        end
        txStop: begin
          if (bsy) begin
            if (baudCnt == BIT_LAST) bsy <= 1'b0;  // frame done and the line left high
          end else begin
            baudCnt <= '0;
            if (!go) state <= txIdle;  // wait for the acknowledge
          end
        end
        default: state <= txIdle;
      endcase
    end
  end

  // the requester drops go only once the frame has finished
  assert property (@(posedge clk) disable iff (rst) $fell(go) |-> $past(!bsy))
    else $error("uartTx: go dropped while busy");

endmodule

// File: src/uartRx.sv
////////////////////
// UART receiver
// 8N1 frames sampled mid-bit, go/data-ready handshake
////////////////////
`timescale 1ns/1ps
`include "ramio_settings.svh"

module uartRx #(
  parameter int CLK_FREQ = `RAMIO_CLK_FREQ,
  parameter int BAUD_RATE = `RAMIO_BAUD_RATE
) (
  input logic clk,
  input logic rst,
  input logic rx,                 // asynchronous serial line
  input logic go,                 // receive enable, low one cycle acknowledges dr
  output ramioPkg::byte_t data,   // complete only while dr is high
  output logic dr                 // data ready
);
  import ramioPkg::*;

  localparam int BIT_CLKS = CLK_FREQ / BAUD_RATE;
  localparam int CNT_W = $clog2(BIT_CLKS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(BIT_CLKS - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BIT_CLKS / 2 - 1);

  uartRxState_t state;
  logic [2:0] rxPipe;         // two sync flops, then the previous level
  logic [CNT_W-1:0] baudCnt;
  logic [2:0] bitIdx;
  logic rxLevel;              // synchronized line
  logic startEdge;            // high to low on the line

  assign rxLevel = rxPipe[1];
  assign startEdge = rxPipe[2] & ~rxPipe[1];

  always_ff @(posedge clk) begin
    if (rst) rxPipe <= 3'b111;  // line idles high
    else rxPipe <= {rxPipe[1:0], rx};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rxIdle;
      dr <= 1'b0;
      baudCnt <= '0;
      bitIdx <= '0;
    end else begin
      baudCnt <= baudCnt + 1'b1;
      unique case (state)
        rxIdle: begin
          baudCnt <= '0;
          if (go && startEdge) state <= rxStart;
        end
        rxStart: if (baudCnt == HALF_LAST) begin  // middle of the start bit
          baudCnt <= '0;
          bitIdx <= '0;
          state <= rxLevel ? rxIdle : rxData;  // glitch, not a start bit
        end
        rxData: if (baudCnt == BIT_LAST) begin
          baudCnt <= '0;
          data <= {rxLevel, data[7:1]};  // LSB first
          bitIdx <= bitIdx + 1'b1;
          if (bitIdx == 3'd7) state <= rxStop;
        end
        rxStop: if (baudCnt == BIT_LAST) begin
          baudCnt <= '0;
          if (rxLevel) begin
            dr <= 1'b1;
            state <= rxDone;
          end else begin
            state <= rxIdle;  // framing error, byte dropped
          end
        end
        rxDone: begin
          baudCnt <= '0;
          if (!go) begin  // acknowledged
            dr <= 1'b0;
            state <= rxIdle;
          end
        end
        default: state <= rxIdle;
      endcase
    end
  end

endmodule

// File: src/ramIo.sv
////////////////////
// memory and I/O block
// RAM data and fetch ports, LED register, UART transmit and receive
////////////////////
`timescale 1ns/1ps
`include "ramio_settings.svh"

module ramIo (
  input logic clk,
  input logic rst,
  // port A, data memory, byte addressed
  input ramioPkg::writeSize_t weA,
  input ramioPkg::readSize_t reA,
  input ramioPkg::byteAddr_t addrA,
  input ramioPkg::word_t dinA,
  output ramioPkg::word_t doutA,   // one cycle after the load
  // port B, instruction fetch, low 2 address bits ignored
  input ramioPkg::byteAddr_t addrB,
  output ramioPkg::word_t doutB,
  output ramioPkg::ledBits_t leds,
  output logic uartTx,
  input logic uartRx
);
  import ramioPkg::*;

  localparam byteAddr_t ADDR_LEDS = byteAddr_t'(`RAMIO_ADDR_LEDS);
  localparam byteAddr_t ADDR_UART_OUT = byteAddr_t'(`RAMIO_ADDR_UART_OUT);
  localparam byteAddr_t ADDR_UART_IN = byteAddr_t'(`RAMIO_ADDR_UART_IN);
  localparam writeSize_t WR_BYTE = 2'd1;
  localparam writeSize_t WR_HALF = 2'd2;
  localparam writeSize_t WR_WORD = 2'd3;
  localparam readSize_t RD_UBYTE = 3'b001;  // the only legal read of UART registers

  ramPort ramBus ();

  readSize_t reAPrev;      // load size of the previous cycle
  byteAddr_t addrAPrev;    // load address of the previous cycle
  word_t laneWord;         // RAM word shifted down to the addressed lane
  byte_t txData;           // byte in flight, zero when idle
  logic txGo;
  logic txBsy;
  logic txLive;            // transmitter has picked up the request
  byte_t rxByte;
  byte_t rxHeld;           // last received byte, cleared on read
  logic rxGo;
  logic rxDr;
  logic uartInRead;

  ram #(.ADDR_WIDTH(`RAMIO_ADDR_WIDTH)) ramBlk (
    .clk(clk),
    .portA(ramBus),
    .addrB(addrB[`RAMIO_ADDR_WIDTH+1:2]),
    .doutB(doutB)
  );

  uartTx #(.CLK_FREQ(`RAMIO_CLK_FREQ), .BAUD_RATE(`RAMIO_BAUD_RATE)) txUnit (
    .clk(clk), .rst(rst), .data(txData), .go(txGo), .tx(uartTx), .bsy(txBsy)
  );

  uartRx #(.CLK_FREQ(`RAMIO_CLK_FREQ), .BAUD_RATE(`RAMIO_BAUD_RATE)) rxUnit (
    .clk(clk), .rst(rst), .rx(uartRx), .go(rxGo), .data(rxByte), .dr(rxDr)
  );

  // store steering, data replicated to all lanes and picked by enables
  always_comb begin
    ramBus.addr = addrA[`RAMIO_ADDR_WIDTH+1:2];
    ramBus.we = '0;
    ramBus.din = '0;
    unique case (weA)
      WR_BYTE: begin
        ramBus.we = byteEn_t'(4'b0001 << addrA[1:0]);
        ramBus.din = {4{dinA[7:0]}};
      end
      WR_HALF: if (!addrA[0]) begin  // odd address dropped
        ramBus.we = addrA[1] ? 4'b1100 : 4'b0011;
        ramBus.din = {2{dinA[15:0]}};
      end
      WR_WORD: if (addrA[1:0] == 2'b00) begin
        ramBus.we = 4'b1111;
        ramBus.din = dinA;
      end
      default: ;  // no store
    endcase
  end

  // read data arrives one cycle later, so size and address go with it
  always_ff @(posedge clk) begin
    if (rst) reAPrev <= '0;
    else reAPrev <= reA;
  end

  always_ff @(posedge clk) addrAPrev <= addrA;

  assign laneWord = ramBus.dout >> {addrAPrev[1:0], 3'b000};
  assign uartInRead = (reAPrev == RD_UBYTE) && (addrAPrev == ADDR_UART_IN);

  // load extraction, sign from the registered size
  always_comb begin
    doutA = '0;
    if (reAPrev == RD_UBYTE && addrAPrev == ADDR_UART_OUT) doutA = {24'b0, txData};
    else if (uartInRead) doutA = {24'b0, rxHeld};
    else begin
      unique case (reAPrev[1:0])
        2'd1: doutA = reAPrev[2] ? {{24{laneWord[7]}}, laneWord[7:0]} : {24'b0, laneWord[7:0]};
        2'd2: if (!addrAPrev[0]) begin
          doutA = reAPrev[2] ? {{16{laneWord[15]}}, laneWord[15:0]} : {16'b0, laneWord[15:0]};
        end
        2'd3: if (addrAPrev[1:0] == 2'b00) doutA = ramBus.dout;
        default: ;  // no load
      endcase
    end
  end

  // I/O registers and both UART handshakes, later assignments win
  always_ff @(posedge clk) begin
    if (rst) begin
      leds <= '1;  // all off
      txData <= '0;
      txGo <= 1'b0;
      txLive <= 1'b0;
      rxHeld <= '0;
      rxGo <= 1'b1;
    end else begin
      if (uartInRead) rxHeld <= '0;  // read once
      if (rxDr && rxGo) begin
        rxHeld <= rxByte;  // newer byte replaces an unread one
        rxGo <= 1'b0;      // one-cycle acknowledge
      end
      if (!rxGo) rxGo <= 1'b1;
      if (txGo && txBsy) txLive <= 1'b1;
      if (txGo && txLive && !txBsy) begin  // frame finished
        txData <= '0;
        txGo <= 1'b0;
        txLive <= 1'b0;
      end
      if (weA == WR_BYTE && addrA == ADDR_LEDS) leds <= dinA[5:0];
      if (weA == WR_BYTE && addrA == ADDR_UART_OUT) begin
        txData <= dinA[7:0];
        txGo <= 1'b1;
        txLive <= 1'b0;
      end
    end
  end

  // the design drops misaligned accesses, the program must not issue them
  assert property (@(posedge clk) disable iff (rst)
    (weA == WR_WORD || reA[1:0] == 2'd3) |-> addrA[1:0] == 2'b00)
    else $error("ramIo: misaligned word access at %h", addrA);
  assert property (@(posedge clk) disable iff (rst)
    (weA == WR_HALF || reA[1:0] == 2'd2) |-> !addrA[0])
    else $error("ramIo: odd half-word access at %h", addrA);

endmodule

// File: verification/ramIoChecker.sv
////////////////////
// ramIo checker
// compares loads, fetches, LEDs and decoded UART frames
////////////////////
`timescale 1ns/1ps

module ramIoChecker (
  input logic clk,
  input logic rst,
  input ramioPkg::word_t doutA,
  input ramioPkg::word_t doutB,
  input ramioPkg::ledBits_t leds,
  input logic serial,               // DUT transmit line
  input logic loadStrobe,           // compare doutA at this edge
  input ramioPkg::word_t loadExp,
  input logic fetchStrobe,
  input ramioPkg::word_t fetchExp,
  input logic ledStrobe,
  input ramioPkg::ledBits_t ledExp,
  input logic frameStrobe,          // queue one expected frame
  input ramioPkg::byte_t frameExp,
  input logic finish,               // end of stimulus
  output int checks,
  output int errors
);
  import ramioPkg::*;

  byte_t expFrames [$];  // frames still to come, in order
  byte_t expByte;
  byte_t shiftIn;        // LSB first
  logic busy;            // decoding a frame
  logic prevLine;
  int bitClk;            // clocks since the start edge was seen

  task automatic logResult(input logic ok, input string what);
    checks++;
    if (ok) $display("PASS %s", what);
    else begin
      errors++;
      $display("ERROR at %0t ns: %s", $time, what);
    end
  endtask

  initial begin
    checks = 0;
    errors = 0;
    busy = 1'b0;
    prevLine = 1'b1;
  end

  always @(posedge clk) begin
    if (loadStrobe) logResult(doutA === loadExp,
      $sformatf("load read %h, expected %h", doutA, loadExp));
    if (fetchStrobe) logResult(doutB === fetchExp,
      $sformatf("fetch read %h, expected %h", doutB, fetchExp));
    if (ledStrobe) logResult(leds === ledExp,
      $sformatf("leds show %h, expected %h", leds, ledExp));
    if (frameStrobe) expFrames.push_back(frameExp);

    if (rst) begin
      busy = 1'b0;
      prevLine = 1'b1;  // line idles high
    end else if (busy) begin
      bitClk++;
      if (bitClk == 76) begin  // middle of the stop bit
        busy = 1'b0;
        if (!serial) begin
          $display("framing error: stop bit low after byte %h", shiftIn);
          errors++;
        end else if (expFrames.size() == 0) begin
          $display("unexpected frame carrying byte %h", shiftIn);
          errors++;
        end else begin
          expByte = expFrames.pop_front();
          logResult(shiftIn === expByte,
            $sformatf("frame carried %h, expected %h", shiftIn, expByte));
        end
      end else if (bitClk % 8 == 4 && bitClk >= 12) begin
        shiftIn = {serial, shiftIn[7:1]};  // mid-bit of data bits
      end
    end else if (prevLine && !serial) begin
      busy = 1'b1;  // start edge, one clock in
      bitClk = 1;
    end
    prevLine = serial;

    if (finish) begin
      if (busy) begin
        $display("a frame was still being sent when the stimulus ended");
        errors++;
      end
      while (expFrames.size() > 0) begin
        $display("missing frame: byte %h never appeared on the UART line",
          expFrames.pop_front());
        errors++;
      end
    end
  end

endmodule

// File: verification/ramIoTb.sv
////////////////////
// ramIo testbench
// file-driven bus operations, UART looped back to the receiver
////////////////////
`timescale 1ns/1ps
`include "ramio_settings.svh"

module ramIoTb;
  import ramioPkg::*;

  localparam int STIM_LINES = 64;
  localparam int STIM_WORDS = 5 * STIM_LINES;  // op, size, addr, data, expected
  localparam int RND_WORDS = 16;

  logic clk = 1'b0;
  logic rst;
  writeSize_t weA;
  readSize_t reA;
  byteAddr_t addrA;
  word_t dinA;
  word_t doutA;
  byteAddr_t addrB;
  word_t doutB;
  ledBits_t leds;
  logic serial;  // loopback line

  logic loadStrobe, loadPend, fetchStrobe, fetchPend;
  word_t loadExp, loadExpPend, fetchExp, fetchExpPend;
  logic ledStrobe, frameStrobe, finish;
  ledBits_t ledExp;
  byte_t frameExp;
  int checks, errors;
  logic badStim = 1'b0;  // stimulus file held an unknown op

  logic [31:0] stim [STIM_WORDS];
  word_t rndWords [RND_WORDS];
  logic [31:0] rngState = 32'hd6d8;
  int cycleCount = 0;
  int limit = 0;

  always #20 clk = ~clk;  // 40 ns period

  ramIo uut (
    .clk(clk), .rst(rst), .weA(weA), .reA(reA), .addrA(addrA), .dinA(dinA),
    .doutA(doutA), .addrB(addrB), .doutB(doutB), .leds(leds),
    .uartTx(serial), .uartRx(serial)
  );

  ramIoChecker chk (
    .clk(clk), .rst(rst), .doutA(doutA), .doutB(doutB), .leds(leds), .serial(serial),
    .loadStrobe(loadStrobe), .loadExp(loadExp), .fetchStrobe(fetchStrobe),
    .fetchExp(fetchExp), .ledStrobe(ledStrobe), .ledExp(ledExp),
    .frameStrobe(frameStrobe), .frameExp(frameExp), .finish(finish),
    .checks(checks), .errors(errors)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // on the falling edge pending strobes go live and the bus returns to idle
  task automatic nextCycle();
    @(negedge clk);
    loadStrobe = loadPend;
    loadExp = loadExpPend;
    fetchStrobe = fetchPend;
    fetchExp = fetchExpPend;
    loadPend = 1'b0;
    fetchPend = 1'b0;
    ledStrobe = 1'b0;
    frameStrobe = 1'b0;
    weA = '0;
    reA = '0;
  endtask

  // transmit byte reads zero once the frame is acknowledged
  task automatic pollTxIdle();
    logic ready;
    ready = 1'b0;
    while (!ready) begin
      reA = 3'b001;
      addrA = byteAddr_t'(`RAMIO_ADDR_UART_OUT);
      nextCycle();
      ready = (doutA == '0);
    end
  endtask

  task automatic runOp(input int op, input int size, input logic [31:0] addr,
                       input logic [31:0] data, input logic [31:0] expVal);
    case (op)
      1: begin  // store
        weA = writeSize_t'(size);
        addrA = byteAddr_t'(addr);
        dinA = data;
        nextCycle();
      end
      2: begin  // load compared one edge later
        reA = readSize_t'(size);
        addrA = byteAddr_t'(addr);
        loadPend = 1'b1;
        loadExpPend = expVal;
        nextCycle();
      end
      3: begin  // fetch on port B
        addrB = byteAddr_t'(addr);
        fetchPend = 1'b1;
        fetchExpPend = expVal;
        nextCycle();
      end
      4: repeat (data) nextCycle();
      5: begin
        ledStrobe = 1'b1;
        ledExp = ledBits_t'(expVal);
        nextCycle();
      end
      6: begin
        frameStrobe = 1'b1;
        frameExp = expVal[7:0];
        nextCycle();
      end
      7: pollTxIdle();
      default: begin
        $display("unknown op %0d in the stimulus file", op);
        badStim = 1'b1;
      end
    endcase
  endtask

  // random words stored, read back, then fetched with the low bits set
  task automatic randomFill();
    for (int i = 0; i < RND_WORDS; i++) begin
      rngState = xorshift(rngState);
      rndWords[i] = rngState;
      runOp(1, 3, 32'h100 + 4 * i, rndWords[i], '0);
    end
    for (int i = 0; i < RND_WORDS; i++) runOp(2, 3, 32'h100 + 4 * i, '0, rndWords[i]);
    for (int i = 0; i < RND_WORDS; i++) runOp(3, 0, 32'h100 + 4 * i + i % 4, '0, rndWords[i]);
  endtask

  always @(posedge clk) cycleCount <= cycleCount + 1;

  initial begin
    wait (limit > 0);
    wait (cycleCount >= limit);
    $display("timeout: the stimulus did not finish within %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int nOps;
    int cycleSum;
    rst = 1'b1;
    weA = '0;
    reA = '0;
    addrA = '0;
    dinA = '0;
    addrB = '0;
    {loadStrobe, loadPend, fetchStrobe, fetchPend, ledStrobe, frameStrobe, finish} = '0;
    {loadExp, loadExpPend, fetchExp, fetchExpPend} = '0;
    ledExp = '0;
    frameExp = '0;
    for (int i = 0; i < STIM_WORDS; i++) stim[i] = '0;  // op 0 ends the list
    $readmemh("verification/ramio_stimulus.txt", stim);
    nOps = 0;
    cycleSum = 3 * RND_WORDS;
    while (nOps < STIM_LINES && stim[5 * nOps] != 0) begin
      if (stim[5 * nOps] == 4 || stim[5 * nOps] == 7) cycleSum += int'(stim[5 * nOps + 3]);
      cycleSum += 1;
      nOps++;
    end
    limit = 2 * cycleSum + 200;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    randomFill();
    for (int i = 0; i < nOps; i++) begin
      runOp(int'(stim[5 * i]), int'(stim[5 * i + 1]), stim[5 * i + 2], stim[5 * i + 3],
            stim[5 * i + 4]);
    end
    finish = 1'b1;
    nextCycle();
    finish = 1'b0;
    nextCycle();
    $display("%0d checks passed or failed, %0d errors", checks, errors);
    if (errors == 0 && !badStim) $display("NO ERRORS");
    else $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: all.f
+incdir+src
src/ramioPkg.sv
src/ramPort.sv
src/ram.sv
src/uartTx.sv
src/uartRx.sv
src/ramIo.sv
verification/ramIoChecker.sv
verification/ramIoTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the ramIo testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 -f all.f --top-module ramIoTb -o ramIoSim

out=$(./obj_dir/ramIoSim)
echo "$out"

# fails the script unless the run passed
grep -qx "NO ERRORS" <<< "$out"

// File: verification/ramio_stimulus.txt
// columns: op size addr data expected, all hex
// op 1 store, 2 load, 3 fetch, 4 wait data cycles, 5 leds, 6 expect frame, 7 poll tx (data = budget)
5 0 000 00000000 0000003f  // leds after reset
1 1 fff 000000a5 00000000  // byte store to LEDs
5 0 000 00000000 00000025
1 3 040 11223344 00000000  // word, then lanes merged over it
1 1 040 123456aa 00000000
1 1 041 0000007f 00000000
1 2 042 9876ccdd 00000000
2 3 040 00000000 ccdd7faa
2 5 040 00000000 ffffffaa  // signed byte
2 1 040 00000000 000000aa
2 5 041 00000000 0000007f
2 5 043 00000000 ffffffcc
2 6 040 00000000 00007faa  // signed half
2 6 042 00000000 ffffccdd
2 2 042 00000000 0000ccdd
3 0 042 00000000 ccdd7faa
6 0 000 00000000 00000041  // single frame
1 1 ffe 00000041 00000000
2 1 ffe 00000000 00000041  // in flight
4 0 000 00000054 00000000
2 1 ffe 00000000 00000000
2 1 ffd 00000000 00000041  // looped back
2 1 ffd 00000000 00000000
6 0 000 00000000 0000005a  // back to back
6 0 000 00000000 000000c3
7 0 000 00000060 00000000
1 1 ffe 0000005a 00000000
7 0 000 00000060 00000000
2 1 ffd 00000000 0000005a
1 1 ffe 000000c3 00000000
7 0 000 00000060 00000000
2 1 ffd 00000000 000000c3
2 1 ffd 00000000 00000000
